// File: filelist.f
source/mul_pkg.sv
source/cla_adder.sv
source/operand_capture.sv
source/radix4_partial_product.sv
source/product_accumulator.sv
source/mul_control.sv
source/result_stage.sv
source/radix4_multiplier.sv
dv/radix4_multiplier_tb.sv

// File: Makefile
TOP := radix4_multiplier_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o $(TOP)

run: compile
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir

// File: dv/radix4_multiplier_tb.sv
// Radix-4 multiplier testbench
`timescale 1ns/1ns

module radix4_multiplier_tb import mul_pkg::*; ();
    localparam int TIMEOUT_CYCLES = 20;
    // Acceptance edge to done edge, and cycles with ready low
    localparam int DONE_EDGES  = 5;
    localparam int BUSY_CYCLES = 4;

    logic       ctl_clk;
    logic       reset;
    operand_t   a;
    operand_t   b;
    logic       trigger;
    operand_t   y;
    logic       ready;
    logic       done;
    operand_t   exp_q[$];
    int         accept_q[$];
    int         cycle = 0;
    int         last_accept = -100;
    int         accept_count = 0;
    int         done_count = 0;
    operand_t   last_y = '0;
    mul_state_e dut_state;

    radix4_multiplier radix4_multiplier_i (
        .ctl_clk (ctl_clk),
        .reset   (reset),
        .a       (a),
        .b       (b),
        .trigger (trigger),
        .y       (y),
        .ready   (ready),
        .done    (done)
    );

    assign dut_state = radix4_multiplier_i.mul_control_i.state;

    // Bits 39 to 8 of the full unsigned product
    function automatic operand_t ref_mul(input operand_t op_a, input operand_t op_b);
        logic [63:0] full;
        full = {32'b0, op_a} * {32'b0, op_b};
        return full[39:8];
    endfunction

    task automatic stop_on_error();
        $display("DUT state at failure: %s", dut_state.name());
        $display("sim failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_result(input operand_t actual, input operand_t expected,
                                input string what);
        if (actual !== expected) begin
            $display("[FAIL] %0t %s: got %h, expected %h", $time, what, actual, expected);
            stop_on_error();
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            $display("[FAIL] %0t %s: got %b, expected %b", $time, what, actual, expected);
            stop_on_error();
        end
    endtask

    task automatic next_cycle();
        @(posedge ctl_clk);
        #1;
    endtask

    task automatic wait_accept(input int target);
        int waited;
        waited = 0;
        while (accept_count < target) begin
            next_cycle();
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                $display("Timeout: trigger was not accepted within %0d cycles", TIMEOUT_CYCLES);
                stop_on_error();
            end
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            next_cycle();
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                $display("Timeout: %0d results still missing", exp_q.size());
                stop_on_error();
            end
        end
    endtask

    task automatic start_product(input operand_t op_a, input operand_t op_b);
        int target;
        target  = accept_count + 1;
        a       = op_a;
        b       = op_b;
        trigger = 1'b1;
        wait_accept(target);
        trigger = 1'b0;
    endtask

    initial begin
        ctl_clk = 1'b0;
        forever #5 ctl_clk = ~ctl_clk;
    end

    always @(posedge ctl_clk) begin
        cycle <= cycle + 1;
    end

    // Outputs are stable at the falling edge
    always @(negedge ctl_clk) begin : compare
        logic     done_exp;
        logic     ready_exp;
        operand_t expected;
        if (reset) begin
            done_exp  = (accept_q.size() != 0) && (accept_q[0] + DONE_EDGES == cycle);
            ready_exp = !((cycle >= last_accept) && (cycle < last_accept + BUSY_CYCLES));
            check_flag(ready, ready_exp, "ready");
            check_flag(done, done_exp, "done");
            if (done) begin
                done_count++;
            end
            if (done_exp) begin
                expected = exp_q.pop_front();
                accept_q.delete(0);
                check_result(y, expected, "product");
                last_y = y;
            end else begin
                check_result(y, last_y, "held y");
            end
            // Next rising edge accepts
            if (trigger && ready) begin
                exp_q.push_back(ref_mul(a, b));
                accept_q.push_back(cycle + 1);
                last_accept = cycle + 1;
                accept_count++;
            end
        end
    end

    initial begin : stimulus
        int before_accepts;
        int before_dones;
        void'($urandom(34520));
        reset    = 1'b0;
        trigger  = 1'b0;
        a        = '0;
        b        = '0;
        repeat (10) @(posedge ctl_clk);
        #1;
        reset = 1'b1;
        @(negedge ctl_clk);
        check_flag(ready, 1'b1, "ready after reset");
        check_flag(done, 1'b0, "done after reset");
        check_result(y, '0, "y after reset");
        next_cycle();

        // Random pairs, some of them back to back
        for (int i = 0; i < 200; i++) begin
            start_product($urandom(), $urandom());
            repeat ($urandom_range(2)) next_cycle();
        end
        wait_drain();

        start_product('0, 32'h1234_5678);
        start_product(32'h89ab_cdef, '0);
        start_product('1, '1);
        start_product(32'd256, 32'hdead_beef);
        wait_drain();
        check_result(last_y, 32'hdead_beef, "multiplicand of 256");

        // Other operands offered while busy
        before_dones = done_count;
        start_product(32'h0001_2345, 32'h0000_0f00);
        a       = 32'h7777_7777;
        b       = 32'h3333_3333;
        trigger = 1'b1;
        repeat (3) next_cycle();
        trigger = 1'b0;
        wait_drain();
        if (done_count != before_dones + 1) begin
            $display("Triggers while busy were accepted: %0d products for one request",
                     done_count - before_dones);
            stop_on_error();
        end

        // Trigger held high, new operands after each acceptance
        before_accepts = accept_count;
        a       = $urandom();
        b       = $urandom();
        trigger = 1'b1;
        for (int i = 1; i <= 6; i++) begin
            wait_accept(before_accepts + i);
            a = $urandom();
            b = $urandom();
        end
        trigger = 1'b0;
        wait_drain();
        repeat (8) next_cycle();

        $display("sim passed");
        $finish;
    end

endmodule

// File: source/radix4_multiplier.sv
// Radix-4 iterative multiplier top
`timescale 1ns/1ns

module radix4_multiplier import mul_pkg::*; (
    input  logic     ctl_clk,
    input  logic     reset,
    input  operand_t a,
    input  operand_t b,
    input  logic     trigger,
    output operand_t y,
    output logic     ready,
    output logic     done
);
    logic                 load;
    logic                 step_en;
    logic                 finish;
    operand_t             mcand;
    logic [STEP_BITS-1:0] b_slice;
    partial_t             partial;
    product_t             product;

    mul_control mul_control_i (
        .ctl_clk (ctl_clk),
        .reset   (reset),
        .trigger (trigger),
        .ready   (ready),
        .load    (load),
        .step_en (step_en),
        .finish  (finish)
    );

    operand_capture operand_capture_i (
        .ctl_clk (ctl_clk),
        .reset   (reset),
        .load    (load),
        .step_en (step_en),
        .a       (a),
        .b       (b),
        .mcand   (mcand),
        .b_slice (b_slice)
    );

    radix4_partial_product radix4_partial_product_i (
        .mcand   (mcand),
        .b_slice (b_slice),
        .partial (partial)
    );

    product_accumulator product_accumulator_i (
        .ctl_clk (ctl_clk),
        .reset   (reset),
        .load    (load),
        .step_en (step_en),
        .partial (partial),
        .product (product)
    );

    result_stage result_stage_i (
        .ctl_clk (ctl_clk),
        .reset   (reset),
        .finish  (finish),
        .product (product),
        .y       (y),
        .done    (done)
    );

endmodule

// File: source/result_stage.sv
// Fixed-point result register
`timescale 1ns/1ns

module result_stage import mul_pkg::*; (
    input  logic     ctl_clk,
    input  logic     reset,
    input  logic     finish,
    input  product_t product,
    output operand_t y,
    output logic     done
);
    always_ff @(posedge ctl_clk) begin
        if (!reset) begin
            y    <= '0;
            done <= 1'b0;
        end else begin
            done <= finish;
            if (finish) begin
                // Drop the low fraction bits
                y <= product[FRAC_BITS+MUL_WIDTH-1:FRAC_BITS];
            end
        end
    end

    // One pulse per product
    assert property (@(posedge ctl_clk) disable iff (!reset)
        done |=> !done);

endmodule

// File: source/mul_control.sv
// Multiplier sequencing FSM
`timescale 1ns/1ns

module mul_control import mul_pkg::*; (
    input  logic ctl_clk,
    input  logic reset,
    input  logic trigger,
    output logic ready,
    output logic load,
    output logic step_en,
    output logic finish
);
    mul_state_e state;
    mul_state_e state_next;
    step_t      count;

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (trigger) begin
                    state_next = ST_CALC;
                end
            end
            ST_CALC: begin
                if (count == step_t'(NUM_STEPS - 1)) begin
                    state_next = ST_DONE;
                end
            end
            ST_DONE: begin
                // Back to back when trigger stays high
                state_next = trigger ? ST_CALC : ST_IDLE;
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge ctl_clk) begin
        if (!reset) begin
            state <= ST_IDLE;
            count <= '0;
        end else begin
            state <= state_next;
            if (load) begin
                count <= '0;
            end else if (step_en) begin
                count <= count + step_t'(1);
            end
        end
    end

    assign ready   = (state == ST_IDLE) || (state == ST_DONE);
    assign load    = trigger && ready;
    assign step_en = (state == ST_CALC);
    assign finish  = (state == ST_DONE);

    // Busy through all calculation steps after acceptance
    assert property (@(posedge ctl_clk) disable iff (!reset)
        load |=> !ready [*NUM_STEPS] ##1 ready);

    assert property (@(posedge ctl_clk) disable iff (!reset)
        count <= step_t'(NUM_STEPS));

endmodule

// File: source/product_accumulator.sv
// Product accumulator
`timescale 1ns/1ns

module product_accumulator import mul_pkg::*; (
    input  logic     ctl_clk,
    input  logic     reset,
    input  logic     load,
    input  logic     step_en,
    input  partial_t partial,
    output product_t product
);
    product_t          acc;
    logic [PART_WIDTH:0] upper_sum;

    // Upper half plus this step's partial product
    cla_adder #(
        .WIDTH (PART_WIDTH)
    ) acc_adder_i (
        .x   (partial),
        .z   ({{STEP_BITS{1'b0}}, acc[2*MUL_WIDTH-1:MUL_WIDTH]}),
        .sum (upper_sum)
    );

    always_ff @(posedge ctl_clk) begin
        if (!reset) begin
            acc <= '0;
        end else if (load) begin
            acc <= '0;
        end else if (step_en) begin
            acc[2*MUL_WIDTH-1:MUL_WIDTH-STEP_BITS] <= upper_sum[PART_WIDTH-1:0];
            // Finished low bits shift down
            acc[MUL_WIDTH-STEP_BITS-1:0] <= acc[MUL_WIDTH-1:STEP_BITS];
        end
    end

    assign product = acc;

endmodule

// File: source/radix4_partial_product.sv
// Radix-4 partial product array
`timescale 1ns/1ns

module radix4_partial_product import mul_pkg::*; (
    input  operand_t             mcand,
    input  logic [STEP_BITS-1:0] b_slice,
    output partial_t             partial
);
    localparam int NUM_DIGITS = STEP_BITS / 2;

    logic [MUL_WIDTH:0]   mcand_x2;
    logic [MUL_WIDTH+1:0] mcand_x3;

    // Multiple table for one radix-4 digit
    assign mcand_x2 = {mcand, 1'b0};

    cla_adder #(
        .WIDTH (MUL_WIDTH + 1)
    ) x3_adder_i (
        .x   ({1'b0, mcand}),
        .z   (mcand_x2),
        .sum (mcand_x3)
    );

    for (genvar i = 0; i < NUM_DIGITS; i++) begin : row
        logic [1:0]           digit;
        logic [MUL_WIDTH+1:0] sel;
        logic [MUL_WIDTH+2:0] sum;

        assign digit = b_slice[2*i +: 2];

        always_comb begin
            case (digit)
                2'd0:    sel = '0;
                2'd1:    sel = {2'b00, mcand};
                2'd2:    sel = {1'b0, mcand_x2};
                default: sel = mcand_x3;
            endcase
        end

        if (i == 0) begin : first
            assign sum = {1'b0, sel};
        end else begin : add
            // Previous row weighs four times less
            cla_adder #(
                .WIDTH (MUL_WIDTH + 2)
            ) row_adder_i (
                .x   (sel),
                .z   ({1'b0, row[i-1].sum[MUL_WIDTH+2:2]}),
                .sum (sum)
            );
        end

        // Two finished bits per row
        assign partial[2*i +: 2] = sum[1:0];
    end

    // A 32 by 8 bit product fits in 40 bits
    assign partial[PART_WIDTH-1:STEP_BITS] = row[NUM_DIGITS-1].sum[MUL_WIDTH+1:2];

endmodule

// File: source/operand_capture.sv
// Operand capture
`timescale 1ns/1ns

module operand_capture import mul_pkg::*; (
    input  logic                 ctl_clk,
    input  logic                 reset,
    input  logic                 load,
    input  logic                 step_en,
    input  operand_t             a,
    input  operand_t             b,
    output operand_t             mcand,
    output logic [STEP_BITS-1:0] b_slice
);
    operand_t mcand_reg;
    operand_t mplier_reg;

    always_ff @(posedge ctl_clk) begin
        if (!reset) begin
            mcand_reg  <= '0;
            mplier_reg <= '0;
        end else if (load) begin
            mcand_reg  <= a;
            mplier_reg <= b;
        end else if (step_en) begin
            // Next slice moves into the low bits
            mplier_reg <= mplier_reg >> STEP_BITS;
        end
    end

    assign mcand   = mcand_reg;
    assign b_slice = mplier_reg[STEP_BITS-1:0];

endmodule

// File: source/cla_adder.sv
// Carry-lookahead adder
`timescale 1ns/1ns

module cla_adder import mul_pkg::*; #(
    parameter int WIDTH = 32
) (
    input  logic [WIDTH-1:0] x,
    input  logic [WIDTH-1:0] z,
    output logic [WIDTH:0]   sum
);
    localparam int NUM_GROUPS = (WIDTH + CLA_GROUP - 1) / CLA_GROUP;
    localparam int PAD_WIDTH  = NUM_GROUPS * CLA_GROUP;

    logic [PAD_WIDTH-1:0] x_pad;
    logic [PAD_WIDTH-1:0] z_pad;
    logic [PAD_WIDTH:0]   sum_pad;
    logic [NUM_GROUPS:0]  group_c;

    // Zero extension up to whole groups
    assign x_pad = PAD_WIDTH'(x);
    assign z_pad = PAD_WIDTH'(z);
    assign group_c[0] = 1'b0;

    for (genvar i = 0; i < NUM_GROUPS; i++) begin : grp
        logic [CLA_GROUP-1:0] g;
        logic [CLA_GROUP-1:0] p;
        logic [CLA_GROUP:1]   c;
        logic                 cin;

        assign cin = group_c[i];
        assign g   = x_pad[i*CLA_GROUP +: CLA_GROUP] & z_pad[i*CLA_GROUP +: CLA_GROUP];
        assign p   = x_pad[i*CLA_GROUP +: CLA_GROUP] ^ z_pad[i*CLA_GROUP +: CLA_GROUP];

        // Two-level carries inside the group
        assign c[1] = g[0] | (cin & p[0]);
        assign c[2] = g[1] | (g[0] & p[1]) | (cin & p[0] & p[1]);
        assign c[3] = g[2] | (g[1] & p[2]) | (g[0] & p[1] & p[2])
                    | (cin & p[0] & p[1] & p[2]);
        assign c[4] = g[3] | (g[2] & p[3]) | (g[1] & p[2] & p[3])
                    | (g[0] & p[1] & p[2] & p[3])
                    | (cin & p[0] & p[1] & p[2] & p[3]);

        assign sum_pad[i*CLA_GROUP +: CLA_GROUP] = p ^ {c[3:1], cin};

        // Group carry ripples on
        assign group_c[i+1] = c[4];
    end

    assign sum_pad[PAD_WIDTH] = group_c[NUM_GROUPS];

    // Padded bits are zero, so the carry lands at bit WIDTH
    assign sum = sum_pad[WIDTH:0];

endmodule

// File: source/mul_pkg.sv
// Radix-4 multiplier definitions
package mul_pkg;

    // Operand and fixed-point format
    localparam int MUL_WIDTH = 32;
    localparam int FRAC_BITS = 8;

    // Multiplier bits retired per cycle, four radix-4 digits
    localparam int STEP_BITS = 8;
    localparam int NUM_STEPS = MUL_WIDTH / STEP_BITS;

    // Partial product of the multiplicand and one slice
    localparam int PART_WIDTH = MUL_WIDTH + STEP_BITS;

    // Lookahead group size of the adders
    localparam int CLA_GROUP = 4;

    typedef logic [MUL_WIDTH-1:0]   operand_t;
    typedef logic [2*MUL_WIDTH-1:0] product_t;
    typedef logic [PART_WIDTH-1:0]  partial_t;
    typedef logic [2:0]             step_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CALC,
        ST_DONE
    } mul_state_e;

endpackage
